// File: vlog.f
common/bram_pkg.sv
logic/bank_router.sv
bank/bank_ram.sv
logic/read_merge.sv
logic/banked_ram_top.sv
tests/tb_banked_ram.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_banked_ram \
  -f vlog.f \
  -o tb_banked_ram \
  && ./obj_dir/tb_banked_ram > sim.log 2>&1 \
  || { echo "build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log

grep -q "PASS: all tests" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: tests/tb_banked_ram.sv
`timescale 1ns/10ps
`default_nettype none

module tb_banked_ram
  import bram_pkg::*;
();

  localparam int BANK_BITS = 2;
  localparam int DEPTH     = 1 << ADDR_W;
  localparam int DRAIN_MAX = 50;

  logic    ram;
  logic    i_rst_n;
  wr_req_t i_wr;
  rd_req_t i_rd;
  rd_rsp_t o_rsp;

  logic [DATA_W-1:0] shadow [DEPTH];  // reference copy of the memory
  rd_rsp_t           exp_q;           // expected response for the read now in flight
  integer            seed;
  int                err_cnt;
  int                chk_cnt;
  int                issued;
  bit                timed_out;

  banked_ram_top #(
    .BANK_BITS (BANK_BITS)
  ) u_dut (
    .ram     (ram),
    .i_rst_n (i_rst_n),
    .i_wr    (i_wr),
    .i_rd    (i_rd),
    .o_rsp   (o_rsp)
  );

  initial begin
    ram = 1'b0;
    forever #2 ram = ~ram;
  end

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                    input logic [DATA_W-1:0] data,
                                                    input logic [DATA_BYTES-1:0] be);
    logic [DATA_W-1:0] w;
    w = old;
    for (int b = 0; b < DATA_BYTES; b++) begin
      if (be[b]) begin
        w[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return w;
  endfunction

  // expected response keeps old contents except bytes written to the same word
  function automatic rd_rsp_t ref_read(input rd_req_t r, input wr_req_t w);
    rd_rsp_t           e;
    logic [DATA_W-1:0] old;
    e       = '0;
    e.valid = r.en;
    old     = shadow[r.addr];
    for (int b = 0; b < DATA_BYTES; b++) begin
      if (w.en && (w.addr == r.addr) && w.be[b]) begin
        e.clash[b] = 1'b1;     // byte comes back as zero
      end else begin
        e.data[b*8 +: 8] = old[b*8 +: 8];
      end
    end
    return e;
  endfunction

  // partial keeps at least one byte untouched
  function automatic logic [DATA_BYTES-1:0] pick_be(input logic [31:0] v, input bit partial);
    logic [DATA_BYTES-1:0] be;
    be = v[DATA_BYTES-1:0];
    if (be == '0 || (partial && be == '1)) begin
      be = DATA_BYTES'(5);
    end
    return be;
  endfunction

  // inputs are stable at the falling edge
  always @(negedge ram) begin
    if (i_rst_n === 1'b1) begin   // o_rsp is undefined before reset
      if (exp_q.valid) begin
        chk_cnt++;
        assert (o_rsp.valid === 1'b1) else begin
          $display("ERR %0t o_rsp.valid got %b exp 1", $time, o_rsp.valid);
          err_cnt++;
        end
        assert (o_rsp.data === exp_q.data) else begin
          $display("ERR %0t o_rsp.data got %h exp %h", $time, o_rsp.data, exp_q.data);
          err_cnt++;
        end
        assert (o_rsp.clash === exp_q.clash) else begin
          $display("ERR %0t o_rsp.clash got %b exp %b", $time, o_rsp.clash, exp_q.clash);
          err_cnt++;
        end
      end else begin
        assert (o_rsp.valid === 1'b0) else begin
          $display("ERR %0t o_rsp.valid got %b exp 0", $time, o_rsp.valid);
          err_cnt++;
        end
      end
    end
    exp_q = ref_read(i_rd, i_wr);
    if (i_wr.en) begin
      shadow[i_wr.addr] = merge_bytes(shadow[i_wr.addr], i_wr.data, i_wr.be);
    end
  end

  task automatic drive(input wr_req_t w, input rd_req_t r);
    @(posedge ram);
    i_wr <= w;
    i_rd <= r;
    if (r.en) begin
      issued++;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    drive('0, '0);
    while (chk_cnt != issued && n < DRAIN_MAX) begin
      @(posedge ram);
      n++;
    end
    if (chk_cnt != issued) begin
      $display("timeout: %0d reads issued but %0d responses seen", issued, chk_cnt);
      timed_out = 1'b1;
    end
  endtask

  task automatic report_test(input string name, input int err0, input int chk0);
    $display("test %s: %0d responses checked, %0d errors", name, chk_cnt - chk0,
             err_cnt - err0);
  endtask

  task automatic fill_and_read_all();
    wr_req_t     w;
    rd_req_t     r;
    logic [31:0] rnd;
    w = '0;
    r = '0;
    for (int i = 0; i < DEPTH; i++) begin
      rnd    = $random(seed);
      w.en   = 1'b1;
      w.addr = i[ADDR_W-1:0];
      w.data = rnd;
      w.be   = '1;
      drive(w, '0);
    end
    for (int i = 0; i < DEPTH; i++) begin   // walks every bank in turn
      r.en   = 1'b1;
      r.addr = i[ADDR_W-1:0];
      drive('0, r);
    end
    wait_drain();
  endtask

  task automatic partial_writes();
    wr_req_t     w;
    rd_req_t     r;
    logic [31:0] rnd;
    for (int i = 0; i < 64; i++) begin
      rnd    = $random(seed);
      w.en   = 1'b1;
      w.addr = rnd[ADDR_W-1:0];
      w.be   = pick_be(rnd >> 16, 1'b1);
      w.data = $random(seed);
      r.en   = 1'b1;
      r.addr = w.addr;
      drive(w, '0);
      drive('0, r);
    end
    wait_drain();
  endtask

  task automatic same_word_clash();
    wr_req_t     w;
    rd_req_t     r;
    logic [31:0] rnd;
    for (int i = 0; i < 32; i++) begin
      rnd    = $random(seed);
      w.en   = 1'b1;
      w.addr = rnd[ADDR_W-1:0];
      w.be   = pick_be(rnd >> 20, 1'b0);
      w.data = $random(seed);
      r.en   = 1'b1;
      r.addr = w.addr;
      drive(w, r);
      drive('0, r);   // the write must now be visible
    end
    wait_drain();
  endtask

  task automatic random_traffic();
    wr_req_t     w;
    rd_req_t     r;
    logic [31:0] rnd;
    logic [31:0] rnd2;
    for (int i = 0; i < 500; i++) begin
      rnd    = $random(seed);
      rnd2   = $random(seed);
      r.en   = 1'b1;
      r.addr = {rnd[ADDR_W-1:BANK_BITS], i[BANK_BITS-1:0]};
      w.en   = rnd2[0];
      w.addr = (rnd2[3:1] == 3'd0) ? r.addr : rnd2[ADDR_W+3:4];
      w.be   = pick_be(rnd2 >> 20, 1'b0);
      w.data = $random(seed);
      drive(w, r);
    end
    wait_drain();
  endtask

  initial begin
    int e0;
    int c0;
    seed      = 32'h694a;
    err_cnt   = 0;
    chk_cnt   = 0;
    issued    = 0;
    timed_out = 1'b0;
    exp_q     = '0;
    i_rst_n   = 1'b0;
    i_wr      = '0;
    i_rd      = '0;
    repeat (10) @(posedge ram);
    i_rst_n <= 1'b1;

    e0 = err_cnt;
    c0 = chk_cnt;
    for (int i = 0; i < 20; i++) begin
      @(negedge ram);
      assert (o_rsp.valid === 1'b0) else begin
        $display("ERR %0t o_rsp.valid got %b exp 0", $time, o_rsp.valid);
        err_cnt++;
      end
    end
    report_test("idle", e0, c0);

    e0 = err_cnt;
    c0 = chk_cnt;
    fill_and_read_all();
    report_test("full_word", e0, c0);
    if (!timed_out) begin
      e0 = err_cnt;
      c0 = chk_cnt;
      partial_writes();
      report_test("partial_be", e0, c0);
    end
    if (!timed_out) begin
      e0 = err_cnt;
      c0 = chk_cnt;
      same_word_clash();
      report_test("clash", e0, c0);
    end
    if (!timed_out) begin
      e0 = err_cnt;
      c0 = chk_cnt;
      random_traffic();
      report_test("random_mix", e0, c0);
    end

    if (timed_out) begin
      $display("run stopped early, a read response never arrived");
    end
    $display("done: %0d responses checked, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/banked_ram_top.sv
`timescale 1ns/10ps
`default_nettype none

module banked_ram_top
  import bram_pkg::*;
#(
  parameter int BANK_BITS = 2
) (
  input  wire logic    ram,
  input  wire logic    i_rst_n,
  input  wire wr_req_t i_wr,
  input  wire rd_req_t i_rd,
  output rd_rsp_t      o_rsp
);

  localparam int NBANK  = 1 << BANK_BITS;
  localparam int WORD_W = ADDR_W - BANK_BITS;   // word index inside a bank
  localparam int BIDX_W = bidx_w(BANK_BITS);

  logic [NBANK-1:0]                 bank_we;
  logic [NBANK-1:0]                 bank_re;
  logic [WORD_W-1:0]                wword;
  logic [WORD_W-1:0]                rword;
  logic [BIDX_W-1:0]                rd_bank;
  logic                             rd_go;
  logic [NBANK-1:0][DATA_W-1:0]     bank_rdata;
  logic [NBANK-1:0][DATA_BYTES-1:0] bank_clash;

  bank_router #(
    .BANK_BITS (BANK_BITS)
  ) u_router (
    .i_wr      (i_wr),
    .i_rd      (i_rd),
    .o_bank_we (bank_we),
    .o_bank_re (bank_re),
    .o_wword   (wword),
    .o_rword   (rword),
    .o_rd_bank (rd_bank),
    .o_rd_go   (rd_go)
  );

  // data and byte enables go to every bank, only the strobes differ
  for (genvar g = 0; g < NBANK; g++) begin : g_bank
    bank_ram #(
      .WORD_W     (WORD_W),
      .DATA_BYTES (DATA_BYTES)
    ) u_bank (
      .ram     (ram),
      .i_we    (bank_we[g]),
      .i_re    (bank_re[g]),
      .i_waddr (wword),
      .i_raddr (rword),
      .i_wdata (i_wr.data),
      .i_be    (i_wr.be),
      .o_rdata (bank_rdata[g]),
      .o_clash (bank_clash[g])
    );
  end

  read_merge #(
    .BANK_BITS (BANK_BITS)
  ) u_merge (
    .ram          (ram),
    .i_rst_n      (i_rst_n),
    .i_rd_go      (rd_go),
    .i_rd_bank    (rd_bank),
    .i_bank_rdata (bank_rdata),
    .i_bank_clash (bank_clash),
    .o_rsp        (o_rsp)
  );

endmodule

`default_nettype wire

// File: logic/read_merge.sv
`timescale 1ns/10ps
`default_nettype none

module read_merge
  import bram_pkg::*;
#(
  parameter int BANK_BITS = 2,
  localparam int NBANK  = 1 << BANK_BITS,
  localparam int BIDX_W = bidx_w(BANK_BITS)
) (
  input  wire logic                                ram,
  input  wire logic                                i_rst_n,
  input  wire logic                                i_rd_go,
  input  wire logic [BIDX_W-1:0]                   i_rd_bank,
  input  wire logic [NBANK-1:0][DATA_W-1:0]        i_bank_rdata,
  input  wire logic [NBANK-1:0][DATA_BYTES-1:0]    i_bank_clash,
  output rd_rsp_t                                  o_rsp
);

  logic              go_q;
  logic [BIDX_W-1:0] bank_q;

  always_ff @(posedge ram) begin
    if (!i_rst_n) begin
      go_q <= 1'b0;
    end else begin
      go_q <= i_rd_go;   // one cycle pulse per read
    end
  end

  // which bank owns the pending read
  always_ff @(posedge ram) begin
    if (i_rd_go) begin
      bank_q <= i_rd_bank;
    end
  end

  // banks already hold registered data, so select without another stage
  always_comb begin
    o_rsp.valid = go_q;
    o_rsp.data  = i_bank_rdata[bank_q];
    o_rsp.clash = i_bank_clash[bank_q];
  end

  a_valid_src: assert property (
    @(posedge ram) disable iff (!i_rst_n)
    $rose(o_rsp.valid) |-> $past(i_rd_go)
  ) else $error("read_merge: response valid without a read");

endmodule

`default_nettype wire

// File: bank/bank_ram.sv
`timescale 1ns/10ps
`default_nettype none

module bank_ram #(
  parameter int WORD_W     = 8,
  parameter int DATA_BYTES = 4,
  localparam int DATA_W    = DATA_BYTES * 8,
  localparam int DEPTH     = 1 << WORD_W
) (
  input  wire logic                  ram,
  input  wire logic                  i_we,
  input  wire logic                  i_re,
  input  wire logic [WORD_W-1:0]     i_waddr,
  input  wire logic [WORD_W-1:0]     i_raddr,
  input  wire logic [DATA_W-1:0]     i_wdata,
  input  wire logic [DATA_BYTES-1:0] i_be,
  output logic [DATA_W-1:0]          o_rdata,
  output logic [DATA_BYTES-1:0]      o_clash
);

  logic [DATA_W-1:0]     mem [DEPTH];
  logic [DATA_W-1:0]     q;
  logic [DATA_BYTES-1:0] clash_q;
  logic                  same_word;

  assign same_word = i_we && i_re && (i_waddr == i_raddr);

  // byte-masked write
  always_ff @(posedge ram) begin
    if (i_we) begin
      for (int b = 0; b < DATA_BYTES; b++) begin
        if (i_be[b]) begin
          mem[i_waddr][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  // registered read, old word on a collision
  always_ff @(posedge ram) begin
    if (i_re) begin
      q       <= mem[i_raddr];
      clash_q <= same_word ? i_be : '0;
    end
  end

  // collided bytes come back as zero
  for (genvar b = 0; b < DATA_BYTES; b++) begin : g_byte
    assign o_rdata[b*8 +: 8] = clash_q[b] ? 8'h00 : q[b*8 +: 8];
  end

  assign o_clash = clash_q;

  // a write with nothing enabled is a caller bug
  a_be_nonzero: assert property (@(posedge ram) i_we |-> (|i_be))
    else $error("bank_ram: write with all byte enables clear");

endmodule

`default_nettype wire

// File: logic/bank_router.sv
`timescale 1ns/10ps
`default_nettype none

module bank_router
  import bram_pkg::*;
#(
  parameter int BANK_BITS = 2,
  localparam int NBANK  = 1 << BANK_BITS,
  localparam int WORD_W = ADDR_W - BANK_BITS,
  localparam int BIDX_W = bidx_w(BANK_BITS)
) (
  input  wire wr_req_t         i_wr,
  input  wire rd_req_t         i_rd,
  output logic [NBANK-1:0]     o_bank_we,
  output logic [NBANK-1:0]     o_bank_re,
  output logic [WORD_W-1:0]    o_wword,
  output logic [WORD_W-1:0]    o_rword,
  output logic [BIDX_W-1:0]    o_rd_bank,
  output logic                 o_rd_go
);

  logic [BIDX_W-1:0] wbank;
  logic [BIDX_W-1:0] rbank;

  // low address bits pick the bank
  if (BANK_BITS == 0) begin : g_single
    assign wbank = '0;
    assign rbank = '0;
  end else begin : g_multi
    assign wbank = i_wr.addr[BANK_BITS-1:0];
    assign rbank = i_rd.addr[BANK_BITS-1:0];
  end

  // the rest is the word inside the bank
  assign o_wword = i_wr.addr[ADDR_W-1:BANK_BITS];
  assign o_rword = i_rd.addr[ADDR_W-1:BANK_BITS];

  always_comb begin
    o_bank_we = '0;
    o_bank_re = '0;
    o_bank_we[wbank] = i_wr.en;
    o_bank_re[rbank] = i_rd.en;
  end

  // merge stage needs to know where the read went
  assign o_rd_bank = rbank;
  assign o_rd_go   = i_rd.en;

  // at most one bank may see each strobe
  always_comb begin
    assert ($onehot0(o_bank_we))
      else $error("bank_router: write strobe hits more than one bank");
    assert ($onehot0(o_bank_re))
      else $error("bank_router: read strobe hits more than one bank");
  end

endmodule

`default_nettype wire

// File: common/bram_pkg.sv
`default_nettype none

package bram_pkg;

  // word geometry
  parameter int DATA_BYTES = 4;
  parameter int DATA_W     = DATA_BYTES * 8;
  parameter int ADDR_W     = 10;   // global word address

  // bank index needs at least one bit, even with a single bank
  function automatic int bidx_w(input int bank_bits);
    return (bank_bits > 0) ? bank_bits : 1;
  endfunction

  // write port request
  typedef struct packed {
    logic                  en;
    logic [ADDR_W-1:0]     addr;
    logic [DATA_W-1:0]     data;
    logic [DATA_BYTES-1:0] be;     // one per byte
  } wr_req_t;

  // read port request
  typedef struct packed {
    logic              en;
    logic [ADDR_W-1:0] addr;
  } rd_req_t;

  // read response, one cycle after the request
  typedef struct packed {
    logic                  valid;
    logic [DATA_W-1:0]     data;
    logic [DATA_BYTES-1:0] clash;  // bytes written in the same cycle
  } rd_rsp_t;

endpackage

`default_nettype wire
